// File: source/main_macros.svh
`ifndef MAIN_MACROS_SVH
`define MAIN_MACROS_SVH

// bus and register widths
`define CPU_ADDR_W    16
`define DATA_W        8
`define IOCTL_ADDR_W  27
`define SCROLL_W      11
`define VRAM_ADDR_W   10
`define LOAD_OFS_W    15

`define ID_BYTE       8'h58

// each cpu map bound closes the region below it
`define ROM1_END      16'h8000
`define ROM2_END      16'hc000
`define VRAM1_BASE    16'hd800
`define VRAM2_BASE    16'hdc00
`define BANK_END      16'he000
`define SPR_END       16'he100

// download image layout
`define DL_ROM2_BASE  27'h0008000
`define DL_BANK1_BASE 27'h000c000
`define DL_BANK2_BASE 27'h000e000
`define DL_END        27'h0010000

// array depths in bytes
`define ROM1_DEPTH    32768
`define ROM2_DEPTH    16384
`define BANK_DEPTH    8192
`define VRAM_DEPTH    1024
`define RAM_DEPTH     8192

`endif

// File: source/main_map_pkg.sv
`include "main_macros.svh"

package main_map_pkg;

  // memory target of a cpu address
  typedef enum logic [2:0] {
    reg_rom1,
    reg_rom2,
    reg_bank,
    reg_vram1,
    reg_vram2,
    reg_spr,
    reg_ram,
    reg_none
  } region_t;

  // i/o port numbers, decoded from addr[7:0]
  typedef enum logic [7:0] {
    port_j1                 = 8'h00,
    port_j2                 = 8'h01,
    port_system             = 8'h02,
    port_p1                 = 8'h03,
    port_p2                 = 8'h04,
    port_bank_flip          = 8'h40,
    port_scroll_x_lo        = 8'h41,
    port_layers_scroll_x_hi = 8'h42,
    port_scroll_y_lo        = 8'h43,
    port_scroll_y_hi        = 8'h44,
    port_snd_latch          = 8'h45,
    port_id                 = 8'hc0
  } io_port_t;

  // download targets
  typedef enum logic [2:0] {
    load_rom1,
    load_rom2,
    load_bank1,
    load_bank2,
    load_none
  } load_region_t;

  typedef struct packed {
    logic                 bank;
    logic                 flip;
    logic [`SCROLL_W-1:0] scroll_x;
    logic [`SCROLL_W-1:0] scroll_y;
    logic [2:0]           layers;
  } video_ctrl_t;

endpackage

// File: source/cpu_bus_if.sv
`timescale 1ns/1ns
`include "main_macros.svh"

// main cpu strobe bus
interface cpu_bus_if;
  logic [`CPU_ADDR_W-1:0] addr;
  logic [`DATA_W-1:0]     wdata;
  logic                   rd;
  logic                   wr;
  logic                   iorq;
  logic                   m1;

  modport source (output addr, wdata, rd, wr, iorq, m1);
  modport mem    (input addr, wdata, wr, iorq);
  modport io     (input addr, wdata, rd, wr, iorq, m1);
endinterface

// registered download write into the program arrays
interface load_if;
  main_map_pkg::load_region_t region;
  logic [`LOAD_OFS_W-1:0]     offset;
  logic [`DATA_W-1:0]         data;
  logic                       we;

  modport loader (output region, offset, data, we);
  modport mem    (input region, offset, data, we);
endinterface

// File: source/rom_loader.sv
`timescale 1ns/1ns
`include "main_macros.svh"

module rom_loader (
  input  logic                     clk_sys,
  input  logic                     rst,
  input  logic                     ioctl_download,
  input  logic [`IOCTL_ADDR_W-1:0] ioctl_addr,
  input  logic [`DATA_W-1:0]       ioctl_dout,
  input  logic                     ioctl_wr,
  load_if.loader                   load
);

  main_map_pkg::load_region_t region_c;
  logic [`IOCTL_ADDR_W-1:0]   base_c;
  logic [`IOCTL_ADDR_W-1:0]   rel_c;

  // anything past the bank2 image is dropped
  always_comb begin
    region_c = main_map_pkg::load_none;
    base_c   = '0;
    if (ioctl_addr < `DL_ROM2_BASE) begin
      region_c = main_map_pkg::load_rom1;
    end else if (ioctl_addr < `DL_BANK1_BASE) begin
      region_c = main_map_pkg::load_rom2;
      base_c   = `DL_ROM2_BASE;
    end else if (ioctl_addr < `DL_BANK2_BASE) begin
      region_c = main_map_pkg::load_bank1;
      base_c   = `DL_BANK1_BASE;
    end else if (ioctl_addr < `DL_END) begin
      region_c = main_map_pkg::load_bank2;
      base_c   = `DL_BANK2_BASE;
    end
  end

  assign rel_c = ioctl_addr - base_c;

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      load.we     <= 1'b0;
      load.region <= main_map_pkg::load_none;
    end else begin
      load.we     <= ioctl_download & ioctl_wr & (region_c != main_map_pkg::load_none);
      load.region <= region_c;
    end
  end

  always_ff @(posedge clk_sys) begin
    load.offset <= rel_c[`LOAD_OFS_W-1:0];
    load.data   <= ioctl_dout;
  end

endmodule

// File: source/main_memory.sv
`timescale 1ns/1ns
`include "main_macros.svh"

module main_memory (
  input  logic                    clk_sys,
  cpu_bus_if.mem                  bus,
  load_if.mem                     load,
  input  logic                    bank,
  input  logic [`VRAM_ADDR_W-1:0] vram_addr,
  output logic [`DATA_W-1:0]      vram1_data,
  output logic [`DATA_W-1:0]      vram2_data,
  output logic [`DATA_W-1:0]      mem_rdata
);

  localparam int ROM1_AW = $clog2(`ROM1_DEPTH);
  localparam int ROM2_AW = $clog2(`ROM2_DEPTH);
  localparam int BANK_AW = $clog2(`BANK_DEPTH);
  localparam int RAM_AW  = $clog2(`RAM_DEPTH);

  main_map_pkg::region_t region_c;
  main_map_pkg::region_t region_q;
  logic                  bank_q;

  logic [`DATA_W-1:0] rom1 [`ROM1_DEPTH];
  logic [`DATA_W-1:0] rom2 [`ROM2_DEPTH];
  logic [`DATA_W-1:0] ram  [`RAM_DEPTH];
  logic [`DATA_W-1:0] rom1_q;
  logic [`DATA_W-1:0] rom2_q;
  logic [`DATA_W-1:0] ram_q;

  // vram sits inside the bank window and only takes writes
  always_comb begin
    if (bus.iorq) begin
      region_c = main_map_pkg::reg_none;
    end else if (bus.addr < `ROM1_END) begin
      region_c = main_map_pkg::reg_rom1;
    end else if (bus.addr < `ROM2_END) begin
      region_c = main_map_pkg::reg_rom2;
    end else if (bus.addr < `BANK_END) begin
      if (bus.addr >= `VRAM2_BASE) begin
        region_c = main_map_pkg::reg_vram2;
      end else if (bus.addr >= `VRAM1_BASE) begin
        region_c = main_map_pkg::reg_vram1;
      end else begin
        region_c = main_map_pkg::reg_bank;
      end
    end else if (bus.addr < `SPR_END) begin
      region_c = main_map_pkg::reg_spr;
    end else begin
      region_c = main_map_pkg::reg_ram;
    end
  end

  // program roms are filled by download only
  always_ff @(posedge clk_sys) begin
    if (load.we && load.region == main_map_pkg::load_rom1) begin
      rom1[load.offset[ROM1_AW-1:0]] <= load.data;
    end
    rom1_q <= rom1[bus.addr[ROM1_AW-1:0]];
  end

  always_ff @(posedge clk_sys) begin
    if (load.we && load.region == main_map_pkg::load_rom2) begin
      rom2[load.offset[ROM2_AW-1:0]] <= load.data;
    end
    rom2_q <= rom2[bus.addr[ROM2_AW-1:0]];
  end

  // bank1 and bank2 share the 0xc000 window
  for (genvar i = 0; i < 2; i++) begin : g_bank
    localparam main_map_pkg::load_region_t LREG =
      (i == 0) ? main_map_pkg::load_bank1 : main_map_pkg::load_bank2;
    logic [`DATA_W-1:0] mem [`BANK_DEPTH];
    logic [`DATA_W-1:0] q;

    always_ff @(posedge clk_sys) begin
      if (load.we && load.region == LREG) begin
        mem[load.offset[BANK_AW-1:0]] <= load.data;
      end
      q <= mem[bus.addr[BANK_AW-1:0]];
    end
  end

  // cpu write port and video read port
  for (genvar i = 0; i < 2; i++) begin : g_vram
    localparam main_map_pkg::region_t VREG =
      (i == 0) ? main_map_pkg::reg_vram1 : main_map_pkg::reg_vram2;
    logic [`DATA_W-1:0] mem [`VRAM_DEPTH];
    logic [`DATA_W-1:0] q;

    always_ff @(posedge clk_sys) begin
      if (bus.wr && region_c == VREG) begin
        mem[bus.addr[`VRAM_ADDR_W-1:0]] <= bus.wdata;
      end
      q <= mem[vram_addr];
    end
  end

  assign vram1_data = g_vram[0].q;
  assign vram2_data = g_vram[1].q;

  always_ff @(posedge clk_sys) begin
    if (bus.wr && region_c == main_map_pkg::reg_ram) begin
      ram[bus.addr[RAM_AW-1:0]] <= bus.wdata;
    end
    ram_q <= ram[bus.addr[RAM_AW-1:0]];
  end

  // select follows the arrays by one cycle
  always_ff @(posedge clk_sys) begin
    region_q <= region_c;
    bank_q   <= bank;
  end

  always_comb begin
    case (region_q)
      main_map_pkg::reg_rom1:  mem_rdata = rom1_q;
      main_map_pkg::reg_rom2:  mem_rdata = rom2_q;
      main_map_pkg::reg_bank,
      main_map_pkg::reg_vram1,
      main_map_pkg::reg_vram2: mem_rdata = bank_q ? g_bank[1].q : g_bank[0].q;
      main_map_pkg::reg_ram:   mem_rdata = ram_q;
      default:                 mem_rdata = '0;
    endcase
  end

endmodule

// File: source/main_io.sv
`timescale 1ns/1ns
`include "main_macros.svh"

module main_io (
  input  logic                      clk_sys,
  input  logic                      rst,
  cpu_bus_if.io                     bus,
  input  logic [`DATA_W-1:0]        mem_rdata,
  input  logic [`DATA_W-1:0]        j1,
  input  logic [`DATA_W-1:0]        j2,
  input  logic [`DATA_W-1:0]        p1,
  input  logic [`DATA_W-1:0]        p2,
  input  logic [`DATA_W-1:0]        system,
  input  logic                      vs,
  input  logic                      snd_clear,
  output main_map_pkg::video_ctrl_t ctrl,
  output logic [`DATA_W-1:0]        snd_latch,
  output logic [`DATA_W-1:0]        cpu_din,
  output logic                      cpu_irq
);

  main_map_pkg::io_port_t port;
  logic                   io_sel;
  logic                   ack;
  logic [`DATA_W-1:0]     io_data;
  logic [1:0]             vs_sr;
  logic                   vs_fall;

  assign port    = main_map_pkg::io_port_t'(bus.addr[7:0]);
  assign io_sel  = bus.iorq & ~bus.m1;
  assign ack     = bus.iorq & bus.m1;
  assign vs_fall = vs_sr[1] & ~vs_sr[0];

  // unmapped input ports read zero
  always_ff @(posedge clk_sys) begin
    if (io_sel) begin
      case (port)
        main_map_pkg::port_j1:     io_data <= j1;
        main_map_pkg::port_j2:     io_data <= j2;
        main_map_pkg::port_system: io_data <= system;
        main_map_pkg::port_p1:     io_data <= p1;
        main_map_pkg::port_p2:     io_data <= p2;
        main_map_pkg::port_id:     io_data <= `ID_BYTE;
        default:                   io_data <= '0;
      endcase
    end
  end

  always_ff @(posedge clk_sys) begin
    if (rst) begin
      ctrl      <= '0;
      snd_latch <= '0;
    end else begin
      if (io_sel && bus.wr) begin
        case (port)
          main_map_pkg::port_bank_flip: begin
            ctrl.bank <= bus.wdata[7];
            ctrl.flip <= bus.wdata[2];
          end
          main_map_pkg::port_scroll_x_lo: ctrl.scroll_x[7:0] <= bus.wdata;
          main_map_pkg::port_layers_scroll_x_hi: begin
            ctrl.layers                 <= bus.wdata[7:5];
            ctrl.scroll_x[`SCROLL_W-1:8] <= bus.wdata[2:0];
          end
          main_map_pkg::port_scroll_y_lo: ctrl.scroll_y[7:0] <= bus.wdata;
          main_map_pkg::port_scroll_y_hi: ctrl.scroll_y[`SCROLL_W-1:8] <= bus.wdata[2:0];
          // bit 0 marks a pending command for the audio side
          main_map_pkg::port_snd_latch: snd_latch <= {bus.wdata[6:0], 1'b1};
          default: ;
        endcase
      end
      if (snd_clear) begin
        snd_latch <= '0;
      end
    end
  end

  // falling vs sets the irq and wins over ack
  always_ff @(posedge clk_sys) begin
    if (rst) begin
      vs_sr   <= 2'b00;
      cpu_irq <= 1'b0;
    end else begin
      vs_sr <= {vs_sr[0], vs};
      if (vs_fall) begin
        cpu_irq <= 1'b1;
      end else if (ack) begin
        cpu_irq <= 1'b0;
      end
    end
  end

  // read data held while rd is low
  always_ff @(posedge clk_sys) begin
    if (bus.rd) begin
      cpu_din <= bus.iorq ? io_data : mem_rdata;
    end
  end

endmodule

// File: source/main_board.sv
`timescale 1ns/1ns
`include "main_macros.svh"

module main_board (
  input  logic                     clk_sys,
  input  logic                     rst,

  input  logic                     ioctl_download,
  input  logic [`IOCTL_ADDR_W-1:0] ioctl_addr,
  input  logic [`DATA_W-1:0]       ioctl_dout,
  input  logic                     ioctl_wr,

  input  logic [`CPU_ADDR_W-1:0]   cpu_addr,
  input  logic [`DATA_W-1:0]       cpu_wdata,
  input  logic                     cpu_rd,
  input  logic                     cpu_wr,
  input  logic                     cpu_iorq,
  input  logic                     cpu_m1,
  output logic [`DATA_W-1:0]       cpu_din,
  output logic                     cpu_irq,

  input  logic [`DATA_W-1:0]       j1,
  input  logic [`DATA_W-1:0]       j2,
  input  logic [`DATA_W-1:0]       p1,
  input  logic [`DATA_W-1:0]       p2,
  input  logic [`DATA_W-1:0]       system,
  input  logic                     vs,

  input  logic                     snd_clear,
  output logic [`DATA_W-1:0]       snd_latch,

  input  logic [`VRAM_ADDR_W-1:0]  vram_addr,
  output logic [`DATA_W-1:0]       vram1_data,
  output logic [`DATA_W-1:0]       vram2_data,
  output logic [`SCROLL_W-1:0]     scroll_x,
  output logic [`SCROLL_W-1:0]     scroll_y,
  output logic [2:0]               layers,
  output logic                     flip
);

  main_map_pkg::video_ctrl_t ctrl;
  logic [`DATA_W-1:0]        mem_rdata;

  cpu_bus_if cpu_bus ();
  load_if    load_bus ();

  assign cpu_bus.addr  = cpu_addr;
  assign cpu_bus.wdata = cpu_wdata;
  assign cpu_bus.rd    = cpu_rd;
  assign cpu_bus.wr    = cpu_wr;
  assign cpu_bus.iorq  = cpu_iorq;
  assign cpu_bus.m1    = cpu_m1;

  rom_loader loader0 (
    .clk_sys        (clk_sys),
    .rst            (rst),
    .ioctl_download (ioctl_download),
    .ioctl_addr     (ioctl_addr),
    .ioctl_dout     (ioctl_dout),
    .ioctl_wr       (ioctl_wr),
    .load           (load_bus.loader)
  );

  main_memory mem0 (
    .clk_sys    (clk_sys),
    .bus        (cpu_bus.mem),
    .load       (load_bus.mem),
    .bank       (ctrl.bank),
    .vram_addr  (vram_addr),
    .vram1_data (vram1_data),
    .vram2_data (vram2_data),
    .mem_rdata  (mem_rdata)
  );

  main_io io0 (
    .clk_sys   (clk_sys),
    .rst       (rst),
    .bus       (cpu_bus.io),
    .mem_rdata (mem_rdata),
    .j1        (j1),
    .j2        (j2),
    .p1        (p1),
    .p2        (p2),
    .system    (system),
    .vs        (vs),
    .snd_clear (snd_clear),
    .ctrl      (ctrl),
    .snd_latch (snd_latch),
    .cpu_din   (cpu_din),
    .cpu_irq   (cpu_irq)
  );

  assign scroll_x = ctrl.scroll_x;
  assign scroll_y = ctrl.scroll_y;
  assign layers   = ctrl.layers;
  assign flip     = ctrl.flip;

endmodule

// File: bench/main_board_sva.sv
`timescale 1ns/1ns

module main_board_sva (
  input logic       clk_sys,
  input logic       rst,
  input logic       cpu_rd,
  input logic       cpu_wr,
  input logic       cpu_irq,
  input logic [7:0] snd_latch
);

  // irq comes out of reset cleared
  irq_after_reset_a: assert property (@(posedge clk_sys) rst |=> !cpu_irq)
    else $error("cpu_irq high in the cycle after reset");

  // a pending command always carries its marker bit
  latch_marker_a: assert property (@(posedge clk_sys) disable iff (rst)
    (snd_latch != 8'h00) |-> snd_latch[0])
    else $error("snd_latch nonzero with bit 0 clear");

  rd_wr_exclusive_a: assert property (@(posedge clk_sys) disable iff (rst)
    !(cpu_rd && cpu_wr))
    else $error("cpu_rd and cpu_wr high together");

endmodule

bind main_board main_board_sva sva0 (
  .clk_sys   (clk_sys),
  .rst       (rst),
  .cpu_rd    (cpu_rd),
  .cpu_wr    (cpu_wr),
  .cpu_irq   (cpu_irq),
  .snd_latch (snd_latch)
);

// File: bench/main_board_tb.sv
`timescale 1ns/1ns
`include "main_macros.svh"

module main_board_tb;

  logic                     clk_sys;
  logic                     rst;
  logic                     ioctl_download;
  logic [`IOCTL_ADDR_W-1:0] ioctl_addr;
  logic [7:0]               ioctl_dout;
  logic                     ioctl_wr;
  logic [15:0]              cpu_addr;
  logic [7:0]               cpu_wdata;
  logic                     cpu_rd;
  logic                     cpu_wr;
  logic                     cpu_iorq;
  logic                     cpu_m1;
  logic [7:0]               cpu_din;
  logic                     cpu_irq;
  logic [7:0]               j1, j2, p1, p2, system;
  logic                     vs;
  logic                     snd_clear;
  logic [7:0]               snd_latch;
  logic [9:0]               vram_addr;
  logic [7:0]               vram1_data, vram2_data;
  logic [10:0]              scroll_x, scroll_y;
  logic [2:0]               layers;
  logic                     flip;

  // reference model
  logic [7:0]  rom1_m [`ROM1_DEPTH];
  logic [7:0]  rom2_m [`ROM2_DEPTH];
  logic [7:0]  bank_m [2][`BANK_DEPTH];
  logic [7:0]  vram_m [2][`VRAM_DEPTH];
  logic [7:0]  ram_m [`RAM_DEPTH];
  logic        sel_bank;
  logic [15:0] rom1_list[$], rom2_list[$], bank1_list[$], bank2_list[$];
  logic [15:0] ram_list[$], vram_list[$];

  main_board dut0 (.*);

  initial begin
    clk_sys = 1'b0;
    forever #2 clk_sys = ~clk_sys;
  end

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      end_with_failure();
    end
  endtask

  function automatic logic [7:0] rand_byte();
    return 8'($urandom);
  endfunction

  function automatic logic [15:0] pick_entry(input logic [15:0] q[$]);
    return q[$urandom_range(0, q.size() - 1)];
  endfunction

  task automatic download_byte(input logic [26:0] addr, input logic [7:0] data);
    @(posedge clk_sys);
    ioctl_download <= 1'b1;
    ioctl_addr     <= addr;
    ioctl_dout     <= data;
    ioctl_wr       <= 1'b1;
    @(posedge clk_sys);
    ioctl_wr <= 1'b0;
  endtask

  task automatic write_cycle(input logic [15:0] addr, input logic io, input logic [7:0] data);
    @(posedge clk_sys);
    cpu_addr  <= addr;
    cpu_wdata <= data;
    cpu_iorq  <= io;
    cpu_wr    <= 1'b1;
    @(posedge clk_sys);
    cpu_wr   <= 1'b0;
    cpu_iorq <= 1'b0;
  endtask

  // rd held for three edges with data valid from the second
  task automatic read_cycle(input logic [15:0] addr, input logic io, output logic [7:0] data);
    @(posedge clk_sys);
    cpu_addr <= addr;
    cpu_iorq <= io;
    cpu_rd   <= 1'b1;
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    data = cpu_din;
    @(posedge clk_sys);
    cpu_rd   <= 1'b0;
    cpu_iorq <= 1'b0;
  endtask

  task automatic ack_cycle();
    @(posedge clk_sys);
    cpu_iorq <= 1'b1;
    cpu_m1   <= 1'b1;
    @(posedge clk_sys);
    cpu_iorq <= 1'b0;
    cpu_m1   <= 1'b0;
  endtask

  function automatic logic [7:0] model_read(input logic [15:0] a);
    if (a < `ROM1_END) return rom1_m[a[14:0]];
    if (a < `ROM2_END) return rom2_m[a[13:0]];
    if (a < `BANK_END) return bank_m[sel_bank][a[12:0]];
    if (a < `SPR_END) return 8'h00;
    return ram_m[a[12:0]];
  endfunction

  task automatic check_read(input logic [15:0] a);
    logic [7:0] d;
    read_cycle(a, 1'b0, d);
    check_value("cpu_din", 32'(d), 32'(model_read(a)));
  endtask

  // rom and bank writes are dropped by the map
  task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
    write_cycle(a, 1'b0, d);
    if (a >= `SPR_END) begin
      ram_m[a[12:0]] = d;
      ram_list.push_back(a);
    end else if (a >= `VRAM1_BASE && a < `BANK_END) begin
      // bit 10 splits d800 from dc00
      vram_m[a[10]][a[9:0]] = d;
      vram_list.push_back(a);
    end
  endtask

  task automatic wait_irq(input logic level, input int limit);
    for (int i = 0; i < limit; i++) begin
      @(negedge clk_sys);
      if (cpu_irq === level) break;
    end
    if (cpu_irq !== level) begin
      $display("cpu_irq did not reach %0d within %0d cycles", level, limit);
      end_with_failure();
    end
  endtask

  initial begin
    logic [7:0]  d, lx, hx, ly, hy;
    logic [7:0]  ins [5];
    logic [15:0] a;
    int          off, hi, sel, k;
    void'($urandom(32'h3b9fbffc));
    rst <= 1'b1;
    ioctl_download <= 1'b0;
    ioctl_addr <= '0;
    ioctl_dout <= '0;
    ioctl_wr <= 1'b0;
    cpu_addr <= '0;
    cpu_wdata <= '0;
    cpu_rd <= 1'b0;
    cpu_wr <= 1'b0;
    cpu_iorq <= 1'b0;
    cpu_m1 <= 1'b0;
    j1 <= '0;
    j2 <= '0;
    p1 <= '0;
    p2 <= '0;
    system <= '0;
    vs <= 1'b0;
    snd_clear <= 1'b0;
    vram_addr <= '0;
    sel_bank = 1'b0;
    repeat (10) @(posedge clk_sys);
    rst <= 1'b0;
    @(negedge clk_sys);
    check_value("cpu_irq", 32'(cpu_irq), 0);
    check_value("snd_latch", 32'(snd_latch), 0);
    check_value("scroll_x", 32'(scroll_x), 0);
    check_value("scroll_y", 32'(scroll_y), 0);
    check_value("layers", 32'(layers), 0);
    check_value("flip", 32'(flip), 0);

    // program download into all four regions
    for (k = 0; k < 512; k++) begin
      off = $urandom_range(0, 'h7fff);
      d = rand_byte();
      download_byte(27'(off), d);
      rom1_m[off[14:0]] = d;
      rom1_list.push_back(off[15:0]);
      off = $urandom_range('h8000, 'hbfff);
      d = rand_byte();
      download_byte(27'(off), d);
      rom2_m[off[13:0]] = d;
      rom2_list.push_back(off[15:0]);
      off = $urandom_range(0, 'h1fff);
      d = rand_byte();
      download_byte(27'(off + 'hc000), d);
      bank_m[0][off[12:0]] = d;
      bank1_list.push_back(16'hc000 | off[15:0]);
      off = $urandom_range(0, 'h1fff);
      d = rand_byte();
      download_byte(27'(off + 'he000), d);
      bank_m[1][off[12:0]] = d;
      bank2_list.push_back(16'hc000 | off[15:0]);
    end
    // bytes past the image aimed at known rom1 addresses
    for (k = 0; k < 64; k++) begin
      a = pick_entry(rom1_list);
      hi = $urandom_range(1, 2047);
      download_byte({hi[10:0], a}, rand_byte());
    end
    @(posedge clk_sys);
    ioctl_download <= 1'b0;
    foreach (rom1_list[i]) check_read(rom1_list[i]);
    foreach (rom2_list[i]) check_read(rom2_list[i]);
    foreach (bank1_list[i]) check_read(bank1_list[i]);

    // bank switch and flip
    for (k = 0; k < 8; k++) begin
      d = rand_byte();
      d[7] = k[0];
      write_cycle({rand_byte(), 8'h40}, 1'b1, d);
      sel_bank = d[7];
      @(negedge clk_sys);
      check_value("flip", 32'(flip), 32'(d[2]));
      repeat (16) begin
        if (sel_bank) check_read(pick_entry(bank2_list));
        else check_read(pick_entry(bank1_list));
      end
    end

    // mixed traffic over the whole map
    for (k = 0; k < 800; k++) begin
      sel = $urandom_range(0, 7);
      case (sel)
        0, 1: mem_write(16'($urandom), rand_byte());
        2: check_read(pick_entry(rom1_list));
        3: check_read(pick_entry(rom2_list));
        4: check_read(16'he000 | 16'($urandom_range(0, 255)));
        5: if (ram_list.size() > 0) check_read(pick_entry(ram_list));
        6: begin
          if (sel_bank) check_read(pick_entry(bank2_list));
          else check_read(pick_entry(bank1_list));
        end
        default: mem_write(pick_entry(rom1_list), rand_byte());
      endcase
    end

    // video side read port
    repeat (64) mem_write(16'($urandom_range('hd800, 'hdfff)), rand_byte());
    foreach (vram_list[i]) begin
      a = vram_list[i];
      @(posedge clk_sys);
      vram_addr <= a[9:0];
      @(posedge clk_sys);
      @(negedge clk_sys);
      if (a[10]) check_value("vram2_data", 32'(vram2_data), 32'(vram_m[1][a[9:0]]));
      else check_value("vram1_data", 32'(vram1_data), 32'(vram_m[0][a[9:0]]));
    end

    // i/o ports
    for (k = 0; k < 8; k++) begin
      for (int n = 0; n < 5; n++) ins[n] = rand_byte();
      @(posedge clk_sys);
      j1 <= ins[0];
      j2 <= ins[1];
      system <= ins[2];
      p1 <= ins[3];
      p2 <= ins[4];
      for (int n = 0; n < 5; n++) begin
        read_cycle({rand_byte(), 8'(n)}, 1'b1, d);
        check_value("cpu_din", 32'(d), 32'(ins[n]));
      end
      read_cycle({rand_byte(), 8'hc0}, 1'b1, d);
      check_value("cpu_din", 32'(d), 32'h58);
      lx = rand_byte();
      hx = rand_byte();
      ly = rand_byte();
      hy = rand_byte();
      write_cycle({rand_byte(), 8'h41}, 1'b1, lx);
      write_cycle({rand_byte(), 8'h42}, 1'b1, hx);
      write_cycle({rand_byte(), 8'h43}, 1'b1, ly);
      write_cycle({rand_byte(), 8'h44}, 1'b1, hy);
      @(negedge clk_sys);
      check_value("scroll_x", 32'(scroll_x), 32'({hx[2:0], lx}));
      check_value("scroll_y", 32'(scroll_y), 32'({hy[2:0], ly}));
      check_value("layers", 32'(layers), 32'(hx[7:5]));
      d = rand_byte();
      write_cycle({rand_byte(), 8'h45}, 1'b1, d);
      @(negedge clk_sys);
      check_value("snd_latch", 32'(snd_latch), 32'({d[6:0], 1'b1}));
      // odd rounds clear in the same cycle as a latch write
      @(posedge clk_sys);
      snd_clear <= 1'b1;
      if (k[0]) begin
        cpu_addr <= {rand_byte(), 8'h45};
        cpu_wdata <= rand_byte();
        cpu_iorq <= 1'b1;
        cpu_wr <= 1'b1;
      end
      @(posedge clk_sys);
      snd_clear <= 1'b0;
      cpu_wr <= 1'b0;
      cpu_iorq <= 1'b0;
      @(negedge clk_sys);
      check_value("snd_latch", 32'(snd_latch), 0);
    end

    // vblank interrupt
    for (k = 0; k < 3; k++) begin
      @(posedge clk_sys);
      vs <= 1'b1;
      repeat ($urandom_range(3, 10)) @(posedge clk_sys);
      @(negedge clk_sys);
      check_value("cpu_irq", 32'(cpu_irq), 0);
      @(posedge clk_sys);
      vs <= 1'b0;
      wait_irq(1'b1, 4);
      repeat (6) begin
        @(negedge clk_sys);
        check_value("cpu_irq", 32'(cpu_irq), 1);
      end
      ack_cycle();
      wait_irq(1'b0, 2);
    end

    // no falling vs since the last ack
    @(negedge clk_sys);
    check_value("cpu_irq", 32'(cpu_irq), 0);
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: all.f
+incdir+source
source/main_map_pkg.sv
source/cpu_bus_if.sv
source/rom_loader.sv
source/main_memory.sv
source/main_io.sv
source/main_board.sv
bench/main_board_sva.sv
bench/main_board_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= main_board_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
